// File: Bender.yml
package:
  name: rename_unit

sources:
  - design/rename_pkg.sv
  - design/free_list.sv
  - design/rename_checkpoint.sv
  - design/mapping_table.sv
  - design/dispatch_stage.sv
  - design/rename_unit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/rename_tb.sv

// File: design/dispatch_stage.sv
/*
 * Dispatch stage
 * One-group output register; emits toward the dispatch queue
 * while credits remain
 */
`timescale 1ns/1ps

module dispatch_stage #(
  parameter int RENAME_WIDTH     = rename_pkg::RENAME_WIDTH,
  parameter int DISPATCH_CREDITS = rename_pkg::DISPATCH_CREDITS
) (
  input  logic                                      clock,
  input  logic                                      reset,

  input  logic                                      grp_valid,
  input  rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prs1,
  input  rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prs2,
  input  rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prd,
  input  rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prev_rd,
  input  logic [RENAME_WIDTH-1:0]                   rd_valid,
  input  logic                                      credit_return,
  output logic                                      slot_free,

  output logic                                      out_valid,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prs1,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prs2,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prd,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prev_rd,
  output logic [RENAME_WIDTH-1:0]                   out_rd_valid
);

  import rename_pkg::*;

  localparam int CREDIT_W = $clog2(DISPATCH_CREDITS + 1);

  slot_state_e          state_q;
  logic [CREDIT_W-1:0]  credit_q;

  assign out_valid = (state_q == SLOT_FULL) && (credit_q != '0);
  assign slot_free = (state_q == SLOT_EMPTY) || out_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= SLOT_EMPTY;
    end else if (grp_valid) begin
      state_q <= SLOT_FULL;
    end else if (out_valid) begin
      state_q <= SLOT_EMPTY;
    end
  end

  // Payload only
  always_ff @(posedge clock) begin
    if (grp_valid) begin
      out_prs1     <= prs1;
      out_prs2     <= prs2;
      out_prd      <= prd;
      out_prev_rd  <= prev_rd;
      out_rd_valid <= rd_valid;
    end
  end

  // One credit per emit, one back per returned queue entry
  always_ff @(posedge clock) begin
    if (reset) begin
      credit_q <= CREDIT_W'(DISPATCH_CREDITS);
    end else begin
      case ({out_valid, credit_return})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// File: design/free_list.sv
/*
 * Free list
 * Bitmap of free physical registers; hands out the lowest free
 * entries in slot order and takes retirements and recovery masks
 */
`timescale 1ns/1ps

module free_list #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH,
  parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
  parameter int ARF_SIZE     = rename_pkg::ARF_SIZE,
  parameter int PRF_SIZE     = rename_pkg::PRF_SIZE
) (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      advance,
  input  logic [RENAME_WIDTH-1:0]                   alloc_req,
  input  logic [COMMIT_WIDTH-1:0]                   retire_valid,
  input  rename_pkg::prf_idx_t [COMMIT_WIDTH-1:0]   retire_prf,
  input  logic                                      recover,
  input  logic [PRF_SIZE-1:0]                       prf_recover,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   alloc_prf,
  output logic                                      allocatable
);

  import rename_pkg::*;

  logic [PRF_SIZE-1:0] free_q;
  logic [PRF_SIZE-1:0] avail;
  logic [PRF_SIZE-1:0] free_next;
  logic                hit;
  logic                all_hit;

  // Each requesting slot claims the lowest entry still left
  always_comb begin
    avail   = free_q;
    all_hit = 1'b1;
    hit     = 1'b0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      alloc_prf[i] = '0;
      hit          = 1'b0;
      if (alloc_req[i]) begin
        for (int j = 0; j < PRF_SIZE; j++) begin
          if (!hit && avail[j]) begin
            hit          = 1'b1;
            alloc_prf[i] = prf_idx_t'(j);
            avail[j]     = 1'b0;
          end
        end
        if (!hit) begin
          all_hit = 1'b0;
        end
      end
    end
    allocatable = all_hit;
  end

  // Claimed entries leave only on advance; retired ones come back
  always_comb begin
    free_next = advance ? avail : free_q;
    for (int k = 0; k < COMMIT_WIDTH; k++) begin
      if (retire_valid[k]) begin
        free_next[retire_prf[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Registers below ARF_SIZE hold the identity map
      for (int j = 0; j < PRF_SIZE; j++) begin
        free_q[j] <= (j >= ARF_SIZE);
      end
    end else if (recover) begin
      free_q <= prf_recover;
    end else begin
      free_q <= free_next;
    end
  end

endmodule

// File: design/mapping_table.sv
/*
 * Rename stage
 * Architectural-to-physical map with in-group bypass, allocation
 * from the free list and branch checkpoints
 */
`timescale 1ns/1ps

module mapping_table #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH,
  parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
  parameter int ARF_SIZE     = rename_pkg::ARF_SIZE,
  parameter int PRF_SIZE     = rename_pkg::PRF_SIZE,
  parameter int CP_COUNT     = rename_pkg::CP_COUNT
) (
  input  logic                                      clock,
  input  logic                                      reset,

  input  logic                                      in_valid,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rs1,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rs2,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rd,
  input  logic [RENAME_WIDTH-1:0]                   rd_valid,
  input  logic                                      check,
  input  rename_pkg::cp_idx_t                       check_idx,

  input  logic                                      recover,
  input  rename_pkg::cp_idx_t                       recover_idx,
  input  logic [PRF_SIZE-1:0]                       prf_recover,

  input  logic [COMMIT_WIDTH-1:0]                   retire_valid,
  input  rename_pkg::prf_idx_t [COMMIT_WIDTH-1:0]   retire_prf,

  input  logic                                      slot_free,
  output logic                                      in_ready,

  output logic                                      grp_valid,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prs1,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prs2,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prd,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   prev_rd
);

  import rename_pkg::*;

  prf_idx_t [ARF_SIZE-1:0]     map_q;
  prf_idx_t [ARF_SIZE-1:0]     map_next;
  prf_idx_t [ARF_SIZE-1:0]     cp_map;
  prf_idx_t [RENAME_WIDTH-1:0] alloc_prf;
  logic                        allocatable;
  logic                        advance;

  // Recovery wins over any transfer in the same cycle
  assign in_ready  = allocatable && slot_free && !recover;
  assign advance   = in_valid && in_ready;
  assign grp_valid = advance;

  free_list #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH),
    .ARF_SIZE     (ARF_SIZE),
    .PRF_SIZE     (PRF_SIZE)
  ) free_list0 (
    .clock        (clock),
    .reset        (reset),
    .advance      (advance),
    .alloc_req    (rd_valid),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf),
    .recover      (recover),
    .prf_recover  (prf_recover),
    .alloc_prf    (alloc_prf),
    .allocatable  (allocatable)
  );

  // Snapshot taken after the whole group, only when it transfers
  rename_checkpoint #(
    .ARF_SIZE    (ARF_SIZE),
    .CP_COUNT    (CP_COUNT)
  ) checkpoint0 (
    .clock       (clock),
    .reset       (reset),
    .check       (check && advance),
    .check_idx   (check_idx),
    .map_in      (map_next),
    .recover_idx (recover_idx),
    .map_out     (cp_map)
  );

  // Sources see earlier slots only, not their own destination
  always_comb begin
    map_next = map_q;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      prs1[i]    = map_next[rs1[i]];
      prs2[i]    = map_next[rs2[i]];
      prev_rd[i] = map_next[rd[i]];
      prd[i]     = '0;
      if (rd_valid[i]) begin
        prd[i]          = alloc_prf[i];
        map_next[rd[i]] = alloc_prf[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARF_SIZE; i++) begin
        map_q[i] <= prf_idx_t'(i);
      end
    end else if (recover) begin
      map_q <= cp_map;
    end else if (advance) begin
      map_q <= map_next;
    end
  end

endmodule

// File: design/rename_checkpoint.sv
/*
 * Rename checkpoint store
 * One mapping table snapshot per checkpoint tag, written at a
 * branch and read back on a mispredict
 */
`timescale 1ns/1ps

module rename_checkpoint #(
  parameter int ARF_SIZE = rename_pkg::ARF_SIZE,
  parameter int CP_COUNT = rename_pkg::CP_COUNT
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  check,
  input  rename_pkg::cp_idx_t                   check_idx,
  input  rename_pkg::prf_idx_t [ARF_SIZE-1:0]   map_in,
  input  rename_pkg::cp_idx_t                   recover_idx,
  output rename_pkg::prf_idx_t [ARF_SIZE-1:0]   map_out
);

  import rename_pkg::*;

  prf_idx_t [ARF_SIZE-1:0] snap [CP_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int c = 0; c < CP_COUNT; c++) begin
        for (int i = 0; i < ARF_SIZE; i++) begin
          snap[c][i] <= prf_idx_t'(i);
        end
      end
    end else if (check) begin
      snap[check_idx] <= map_in;
    end
  end

  assign map_out = snap[recover_idx];

endmodule

// File: design/rename_pkg.sv
/*
 * Rename package
 * Group and file sizes, register index types and the
 * state encoding of the dispatch register
 */
package rename_pkg;

  // Instructions renamed per group
  parameter int RENAME_WIDTH = 2;

  // Physical registers retired per cycle
  parameter int COMMIT_WIDTH = 2;

  // Integer register files
  parameter int ARF_SIZE = 32;
  parameter int PRF_SIZE = 64;

  // Branch checkpoints held by the rename stage
  parameter int CP_COUNT = 4;

  // Entries the dispatch queue grants after reset
  parameter int DISPATCH_CREDITS = 4;

  // Index widths follow the sizes above
  parameter int ARF_IDX_W = $clog2(ARF_SIZE);
  parameter int PRF_IDX_W = $clog2(PRF_SIZE);
  parameter int CP_IDX_W  = $clog2(CP_COUNT);

  // Architectural register index
  typedef logic [ARF_IDX_W-1:0] arf_idx_t;

  // Physical register index
  typedef logic [PRF_IDX_W-1:0] prf_idx_t;

  // Checkpoint tag
  typedef logic [CP_IDX_W-1:0] cp_idx_t;

  // Dispatch register occupancy
  typedef enum logic {
    SLOT_EMPTY,
    SLOT_FULL
  } slot_state_e;

endpackage

// File: design/rename_unit.sv
/*
 * Integer rename unit
 * Rename stage followed by the credit-controlled dispatch register
 */
`timescale 1ns/1ps

module rename_unit #(
  parameter int RENAME_WIDTH     = rename_pkg::RENAME_WIDTH,
  parameter int COMMIT_WIDTH     = rename_pkg::COMMIT_WIDTH,
  parameter int ARF_SIZE         = rename_pkg::ARF_SIZE,
  parameter int PRF_SIZE         = rename_pkg::PRF_SIZE,
  parameter int CP_COUNT         = rename_pkg::CP_COUNT,
  parameter int DISPATCH_CREDITS = rename_pkg::DISPATCH_CREDITS
) (
  input  logic                                      clock,
  input  logic                                      reset,

  input  logic                                      in_valid,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rs1,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rs2,
  input  rename_pkg::arf_idx_t [RENAME_WIDTH-1:0]   rd,
  input  logic [RENAME_WIDTH-1:0]                   rd_valid,
  input  logic                                      check,
  input  rename_pkg::cp_idx_t                       check_idx,
  output logic                                      in_ready,

  input  logic                                      recover,
  input  rename_pkg::cp_idx_t                       recover_idx,
  input  logic [PRF_SIZE-1:0]                       prf_recover,

  input  logic [COMMIT_WIDTH-1:0]                   retire_valid,
  input  rename_pkg::prf_idx_t [COMMIT_WIDTH-1:0]   retire_prf,

  output logic                                      out_valid,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prs1,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prs2,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prd,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0]   out_prev_rd,
  output logic [RENAME_WIDTH-1:0]                   out_rd_valid,
  input  logic                                      credit_return
);

  import rename_pkg::*;

  logic                        grp_valid;
  logic                        slot_free;
  prf_idx_t [RENAME_WIDTH-1:0] ren_prs1;
  prf_idx_t [RENAME_WIDTH-1:0] ren_prs2;
  prf_idx_t [RENAME_WIDTH-1:0] ren_prd;
  prf_idx_t [RENAME_WIDTH-1:0] ren_prev_rd;

  mapping_table #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH),
    .ARF_SIZE     (ARF_SIZE),
    .PRF_SIZE     (PRF_SIZE),
    .CP_COUNT     (CP_COUNT)
  ) mapping_table0 (
    .clock        (clock),
    .reset        (reset),
    .in_valid     (in_valid),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .rd_valid     (rd_valid),
    .check        (check),
    .check_idx    (check_idx),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .prf_recover  (prf_recover),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf),
    .slot_free    (slot_free),
    .in_ready     (in_ready),
    .grp_valid    (grp_valid),
    .prs1         (ren_prs1),
    .prs2         (ren_prs2),
    .prd          (ren_prd),
    .prev_rd      (ren_prev_rd)
  );

  dispatch_stage #(
    .RENAME_WIDTH     (RENAME_WIDTH),
    .DISPATCH_CREDITS (DISPATCH_CREDITS)
  ) dispatch_stage0 (
    .clock         (clock),
    .reset         (reset),
    .grp_valid     (grp_valid),
    .prs1          (ren_prs1),
    .prs2          (ren_prs2),
    .prd           (ren_prd),
    .prev_rd       (ren_prev_rd),
    .rd_valid      (rd_valid),
    .credit_return (credit_return),
    .slot_free     (slot_free),
    .out_valid     (out_valid),
    .out_prs1      (out_prs1),
    .out_prs2      (out_prs2),
    .out_prd       (out_prd),
    .out_prev_rd   (out_prev_rd),
    .out_rd_valid  (out_rd_valid)
  );

endmodule

// File: sim.f
+incdir+testbench
design/rename_pkg.sv
design/free_list.sv
design/rename_checkpoint.sv
design/mapping_table.sv
design/dispatch_stage.sv
design/rename_unit.sv
testbench/rename_tb.sv

// File: testbench/rename_model.svh
/*
 * Rename reference model
 * Map, free bitmap, checkpoints, credits and expected groups,
 * updated from the transfers seen at the DUT ports
 */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct packed {
  logic [RENAME_WIDTH-1:0]     rd_valid;
  prf_idx_t [RENAME_WIDTH-1:0] prs1;
  prf_idx_t [RENAME_WIDTH-1:0] prs2;
  prf_idx_t [RENAME_WIDTH-1:0] prd;
  prf_idx_t [RENAME_WIDTH-1:0] prev_rd;
} grp_t;

int   m_map [ARF_SIZE];
bit   m_free [PRF_SIZE];
int   m_cp [CP_COUNT][ARF_SIZE];
int   m_credits;
bit   m_full;
int   m_retire_q [$];
grp_t m_exp_q [$];

function automatic void model_reset();
  for (int i = 0; i < ARF_SIZE; i++) begin
    m_map[i] = i;
    for (int c = 0; c < CP_COUNT; c++) begin
      m_cp[c][i] = i;
    end
  end
  for (int p = 0; p < PRF_SIZE; p++) begin
    m_free[p] = (p >= ARF_SIZE);
  end
  m_credits = DISPATCH_CREDITS;
  m_full    = 1'b0;
  m_retire_q.delete();
  m_exp_q.delete();
endfunction

function automatic int free_count();
  int n;
  n = 0;
  foreach (m_free[p]) begin
    n += m_free[p];
  end
  return n;
endfunction

// In-order rename of one accepted group
function automatic void rename_group(input arf_idx_t [RENAME_WIDTH-1:0] s1,
                                     input arf_idx_t [RENAME_WIDTH-1:0] s2,
                                     input arf_idx_t [RENAME_WIDTH-1:0] d,
                                     input logic [RENAME_WIDTH-1:0] dv,
                                     input bit ck,
                                     input int ck_idx);
  grp_t g;
  int   pick;
  g = '0;
  g.rd_valid = dv;
  for (int i = 0; i < RENAME_WIDTH; i++) begin
    g.prs1[i]    = prf_idx_t'(m_map[s1[i]]);
    g.prs2[i]    = prf_idx_t'(m_map[s2[i]]);
    g.prev_rd[i] = prf_idx_t'(m_map[d[i]]);
    if (dv[i]) begin
      // Downward scan leaves the lowest free entry
      pick = 0;
      for (int p = PRF_SIZE - 1; p >= 0; p--) begin
        if (m_free[p]) begin
          pick = p;
        end
      end
      m_free[pick] = 1'b0;
      g.prd[i]     = prf_idx_t'(pick);
      m_map[d[i]]  = pick;
      m_retire_q.push_back(g.prev_rd[i]);
    end
  end
  if (ck) begin
    m_cp[ck_idx] = m_map;
  end
  m_exp_q.push_back(g);
endfunction

// Everything outside the snapshot map is free after recovery
function automatic logic [PRF_SIZE-1:0] recover_mask(input int t);
  logic [PRF_SIZE-1:0] mask;
  mask = '1;
  for (int i = 0; i < ARF_SIZE; i++) begin
    mask[m_cp[t][i]] = 1'b0;
  end
  return mask;
endfunction

function automatic void recover_to(input int t, input logic [PRF_SIZE-1:0] mask);
  m_map = m_cp[t];
  for (int p = 0; p < PRF_SIZE; p++) begin
    m_free[p] = mask[p];
  end
  m_retire_q.delete();
endfunction

`endif

// File: testbench/rename_tb.sv
/*
 * Rename unit testbench
 * Random groups, retirements, checkpoints and recoveries checked
 * against a reference model, with random credit returns
 */
`timescale 1ns/1ps

module rename_tb;

  import rename_pkg::*;

  localparam int    NUM_CYCLES   = 2000;
  localparam int    RESET_CYCLES = 10;
  localparam int    STALL_START  = 800;
  localparam int    STALL_END    = 860;
  localparam int    MARGIN       = 200;
  localparam longint TIMEOUT_NS  = (NUM_CYCLES + RESET_CYCLES + MARGIN) * 20;

  `include "rename_model.svh"

  logic                          clock;
  logic                          reset;
  logic                          in_valid;
  arf_idx_t [RENAME_WIDTH-1:0]   rs1;
  arf_idx_t [RENAME_WIDTH-1:0]   rs2;
  arf_idx_t [RENAME_WIDTH-1:0]   rd;
  logic [RENAME_WIDTH-1:0]       rd_valid;
  logic                          check;
  cp_idx_t                       check_idx;
  logic                          in_ready;
  logic                          recover;
  cp_idx_t                       recover_idx;
  logic [PRF_SIZE-1:0]           prf_recover;
  logic [COMMIT_WIDTH-1:0]       retire_valid;
  prf_idx_t [COMMIT_WIDTH-1:0]   retire_prf;
  logic                          out_valid;
  prf_idx_t [RENAME_WIDTH-1:0]   out_prs1;
  prf_idx_t [RENAME_WIDTH-1:0]   out_prs2;
  prf_idx_t [RENAME_WIDTH-1:0]   out_prd;
  prf_idx_t [RENAME_WIDTH-1:0]   out_prev_rd;
  logic [RENAME_WIDTH-1:0]       out_rd_valid;
  logic                          credit_return;

  int errors;
  int accepted;
  int emitted;
  int cyc;
  int ret_due [$];

  rename_unit #(
    .RENAME_WIDTH     (RENAME_WIDTH),
    .COMMIT_WIDTH     (COMMIT_WIDTH),
    .ARF_SIZE         (ARF_SIZE),
    .PRF_SIZE         (PRF_SIZE),
    .CP_COUNT         (CP_COUNT),
    .DISPATCH_CREDITS (DISPATCH_CREDITS)
  ) dut0 (
    .clock         (clock),
    .reset         (reset),
    .in_valid      (in_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .rd_valid      (rd_valid),
    .check         (check),
    .check_idx     (check_idx),
    .in_ready      (in_ready),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .prf_recover   (prf_recover),
    .retire_valid  (retire_valid),
    .retire_prf    (retire_prf),
    .out_valid     (out_valid),
    .out_prs1      (out_prs1),
    .out_prs2      (out_prs2),
    .out_prd       (out_prd),
    .out_prev_rd   (out_prev_rd),
    .out_rd_valid  (out_rd_valid),
    .credit_return (credit_return)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // Fixed first group after reset
  task automatic drive_first();
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      rs1[i] = arf_idx_t'(i + 1);
      rs2[i] = arf_idx_t'(i + 10);
      rd[i]  = arf_idx_t'(i + 20);
    end
    in_valid = 1'b1;
    rd_valid = '1;
  endtask

  task automatic drive_random(input bit active);
    bit stalled;
    int span;
    stalled = (cyc >= STALL_START) && (cyc < STALL_END);
    // Narrow index range makes in-group hazards common
    span    = ($urandom_range(0, 1) == 1) ? 7 : ARF_SIZE - 1;
    in_valid = active && (stalled || $urandom_range(0, 3) != 0);
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      rs1[i] = arf_idx_t'($urandom_range(0, span));
      rs2[i] = arf_idx_t'($urandom_range(0, span));
      rd[i]  = arf_idx_t'($urandom_range(0, span));
    end
    rd_valid    = RENAME_WIDTH'($urandom_range(0, (1 << RENAME_WIDTH) - 1));
    check       = ($urandom_range(0, 7) == 0);
    check_idx   = cp_idx_t'($urandom_range(0, CP_COUNT - 1));
    recover     = active && !stalled && ($urandom_range(0, 31) == 0);
    recover_idx = cp_idx_t'($urandom_range(0, CP_COUNT - 1));
    prf_recover = recover ? recover_mask(recover_idx) : '0;
    retire_valid = '0;
    retire_prf   = '0;
    for (int k = 0; k < COMMIT_WIDTH; k++) begin
      if (!recover && m_retire_q.size() != 0 && $urandom_range(0, 2) == 0) begin
        retire_valid[k] = 1'b1;
        retire_prf[k]   = prf_idx_t'(m_retire_q.pop_front());
      end
    end
    credit_return = 1'b0;
    if (!stalled && ret_due.size() != 0 && ret_due[0] <= cyc) begin
      credit_return = 1'b1;
      void'(ret_due.pop_front());
    end
  endtask

  // Compare at mid-cycle, then advance the model past the next edge
  task automatic sample_and_update();
    grp_t g;
    bit   exp_out;
    bit   exp_ready;
    exp_out   = m_full && (m_credits > 0);
    exp_ready = (free_count() >= $countones(rd_valid)) && (!m_full || exp_out) && !recover;
    check_value("out_valid", out_valid, exp_out);
    check_value("in_ready", in_ready, exp_ready);
    if (out_valid) begin
      if (m_exp_q.size() == 0) begin
        errors++;
        $display("unexpected group on the dispatch output at %0t", $time);
      end else begin
        g = m_exp_q.pop_front();
        check_value("out_rd_valid", out_rd_valid, g.rd_valid);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
          check_value($sformatf("out_prs1[%0d]", i), out_prs1[i], g.prs1[i]);
          check_value($sformatf("out_prs2[%0d]", i), out_prs2[i], g.prs2[i]);
          check_value($sformatf("out_prev_rd[%0d]", i), out_prev_rd[i], g.prev_rd[i]);
          if (g.rd_valid[i]) begin
            check_value($sformatf("out_prd[%0d]", i), out_prd[i], g.prd[i]);
          end
          if (emitted == 0) begin
            check_value("first prs1", out_prs1[i], i + 1);
            check_value("first prd", out_prd[i], ARF_SIZE + i);
          end
        end
      end
      emitted++;
      m_credits--;
      m_full = 1'b0;
      ret_due.push_back(cyc + $urandom_range(1, 4));
    end
    if (credit_return) begin
      m_credits++;
    end
    if (in_valid && exp_ready) begin
      rename_group(rs1, rs2, rd, rd_valid, check, check_idx);
      m_full = 1'b1;
      accepted++;
    end
    for (int k = 0; k < COMMIT_WIDTH; k++) begin
      if (retire_valid[k]) begin
        m_free[retire_prf[k]] = 1'b1;
      end
    end
    if (recover) begin
      recover_to(recover_idx, prf_recover);
    end
    if (cyc == STALL_END - 1) begin
      check_value("in_ready without credits", in_ready, 0);
    end
  endtask

  initial begin
    void'($urandom(32'hc17b040c));
    errors   = 0;
    accepted = 0;
    emitted  = 0;
    cyc      = 0;
    reset    = 1'b1;
    in_valid = 1'b0;
    rs1      = '0;
    rs2      = '0;
    rd       = '0;
    rd_valid = '0;
    check    = 1'b0;
    check_idx     = '0;
    recover       = 1'b0;
    recover_idx   = '0;
    prf_recover   = '0;
    retire_valid  = '0;
    retire_prf    = '0;
    credit_return = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
    model_reset();
    // Random phase, then drain until the last group has left
    while (cyc < NUM_CYCLES || m_exp_q.size() != 0) begin
      if (cyc == 0) begin
        drive_first();
      end else begin
        drive_random(cyc < NUM_CYCLES);
      end
      @(negedge clock);
      sample_and_update();
      @(posedge clock);
      #2;
      cyc++;
    end
    check_value("groups emitted", emitted, accepted);
    $display("summary: %0d errors, %0d groups accepted, %0d groups emitted",
             errors, accepted, emitted);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
